//--- mhq_macros.svh
// ==========================================================
// Miss handling queue sizes
// Address and data widths, cache line geometry and the
// number of queue entries shared by every block
// ==========================================================

`ifndef MHQ_MACROS_SVH
`define MHQ_MACROS_SVH

// Width of a byte address from the load/store unit
`define MHQ_ADDR_WIDTH 32

// Width of one store data word
`define MHQ_DATA_WIDTH 32

// Cache line size in bytes and the matching offset width
`define MHQ_LINE_SIZE 16
`define MHQ_OFFSET_WIDTH 4

// Number of queue entries and the width of an entry index
`define MHQ_DEPTH 4
`define MHQ_IDX_WIDTH 2

`endif

//--- mhq_pkg.sv
// ==========================================================
// Miss handling queue types
// Opcode and fill state encodings plus the packed structs
// passed between the lookup, entry array and control
// ==========================================================

`include "mhq_macros.svh"

package mhq_pkg;

    // Operations presented by the load/store unit
    typedef enum logic [2:0] {
        OP_LOAD,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_FILL
    } mhq_op_e;

    // States of the head entry fill sequence
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_WAIT,
        ST_FILL
    } mhq_fill_state_e;

    typedef logic [`MHQ_LINE_SIZE*8-1:0]                  mhq_line_t;
    typedef logic [`MHQ_ADDR_WIDTH-`MHQ_OFFSET_WIDTH-1:0] mhq_line_addr_t;
    typedef logic [`MHQ_LINE_SIZE-1:0]                    mhq_byte_mask_t;
    typedef logic [`MHQ_DEPTH-1:0]                        mhq_select_t;
    typedef logic [`MHQ_IDX_WIDTH-1:0]                    mhq_idx_t;

    // One lookup from the load/store unit
    typedef struct packed {
        logic                       we;
        logic                       dc_hit;
        logic [`MHQ_ADDR_WIDTH-1:0] addr;
        mhq_op_e                    op;
        logic [`MHQ_DATA_WIDTH-1:0] data;
    } mhq_lookup_req_t;

    typedef struct packed {
        mhq_idx_t tag;
        logic     retry;
        logic     replay;
    } mhq_lookup_rsp_t;

    // Registered write into one entry that the lookup also sees as the bypass
    typedef struct packed {
        mhq_select_t    select;
        logic           we;
        mhq_line_addr_t addr;
        mhq_byte_mask_t byte_select;
        mhq_line_t      wr_data;
    } mhq_update_t;

    // Head entry contents as seen by the control module
    typedef struct packed {
        mhq_line_addr_t addr;
        logic           dirty;
        mhq_byte_mask_t mask;
        mhq_line_t      data;
    } mhq_entry_t;

    typedef struct packed {
        mhq_line_addr_t addr;
        mhq_line_t      line;
    } mhq_fill_t;

    typedef struct packed {
        mhq_line_addr_t addr;
    } mhq_mem_req_t;

endpackage

//--- mhq_lookup.sv
// ==========================================================
// Miss handling queue lookup stage
// Picks the entry for a missed line, decides retry, replay
// and allocation, and builds the shifted store update
// ==========================================================

`timescale 1ns/1ns
`include "mhq_macros.svh"

module mhq_lookup (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  mhq_pkg::mhq_lookup_req_t    i_req,
    input  logic                        i_full,
    input  mhq_pkg::mhq_select_t        i_hit_select,
    input  mhq_pkg::mhq_select_t        i_alloc_select,
    input  mhq_pkg::mhq_select_t        i_bypass_select,
    input  mhq_pkg::mhq_line_addr_t     i_bypass_addr,
    input  logic                        i_completing,
    input  mhq_pkg::mhq_line_addr_t     i_completing_addr,
    input  logic                        i_filling,
    input  mhq_pkg::mhq_line_addr_t     i_filling_addr,
    output mhq_pkg::mhq_lookup_rsp_t    o_rsp,
    output logic                        o_rsp_valid,
    output logic                        o_allocating,
    output mhq_pkg::mhq_update_t        o_update
);
    import mhq_pkg::*;

    mhq_line_addr_t                 lookup_line;
    logic [`MHQ_OFFSET_WIDTH-1:0]   lookup_offset;
    logic                           entry_hit;
    logic                           bypass_hit;
    logic                           lookup_hit;
    mhq_select_t                    lookup_select;
    mhq_idx_t                       lookup_tag;
    logic                           retry;
    logic                           replay;
    logic                           update_en;
    mhq_byte_mask_t                 byte_select;
    mhq_line_t                      wr_data;

    assign lookup_line   = i_req.addr[`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH];
    assign lookup_offset = i_req.addr[`MHQ_OFFSET_WIDTH-1:0];

    // The entry written on this cycle is not yet valid in the array, so its
    // address is compared here directly
    assign entry_hit  = |i_hit_select;
    assign bypass_hit = (|i_bypass_select) && (i_bypass_addr == lookup_line);
    assign lookup_hit = i_valid && (entry_hit || bypass_hit);

    // Bypass entry wins over a stored hit, and the tail is used when neither matches
    always_comb begin
        if (bypass_hit) begin
            lookup_select = i_bypass_select;
        end else if (entry_hit) begin
            lookup_select = i_hit_select;
        end else begin
            lookup_select = i_alloc_select;
        end
    end

    // One-hot to binary tag
    always_comb begin
        lookup_tag = '0;
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            if (lookup_select[i]) begin
                lookup_tag = mhq_idx_t'(i);
            end
        end
    end

    // A full queue can still take stores that merge into an existing entry
    assign retry = i_full && !lookup_hit;

    // The completing and filling lines are about to leave the queue, so
    // anything that lands on them now would be lost
    assign replay = (i_completing && (i_completing_addr == lookup_line))
                  || (i_filling && (i_filling_addr == lookup_line));

    assign update_en = i_valid && !i_req.dc_hit && (i_req.op != OP_FILL)
                     && !retry && !replay;
    assign o_allocating = update_en && !lookup_hit;

    // Byte select for the store size, shifted to the line offset
    // Bytes pushed beyond the top of the line drop off, which clips the store
    always_comb begin
        unique case (i_req.op)
            OP_SB:   byte_select = mhq_byte_mask_t'(1'b1);
            OP_SH:   byte_select = mhq_byte_mask_t'(2'b11);
            OP_SW:   byte_select = mhq_byte_mask_t'({(`MHQ_DATA_WIDTH/8){1'b1}});
            default: byte_select = '0;
        endcase
        byte_select = byte_select << lookup_offset;
    end

    // Store data moved to the same byte lanes as the select
    assign wr_data = mhq_line_t'(i_req.data) << {lookup_offset, 3'b000};

    always_ff @(posedge clk) begin
        o_rsp.tag            <= lookup_tag;
        o_rsp.retry          <= retry;
        o_rsp.replay         <= replay;
        o_update.we          <= i_req.we;
        o_update.addr        <= lookup_line;
        o_update.byte_select <= byte_select;
        o_update.wr_data     <= wr_data;
        if (i_reset) begin
            o_rsp_valid     <= 1'b0;
            o_update.select <= '0;
        end else begin
            o_rsp_valid     <= i_valid;
            o_update.select <= update_en ? lookup_select : '0;
        end
    end

    // Exactly one entry or none is written per cycle
    assert property (@(posedge clk) disable iff (i_reset) $onehot0(o_update.select));

endmodule

//--- mhq_entry_array.sv
// ==========================================================
// Miss handling queue entry array
// Stores line address, merged store bytes, byte mask and
// dirty flag per entry; matches lookups against them
// ==========================================================

`timescale 1ns/1ns
`include "mhq_macros.svh"

module mhq_entry_array (
    input  logic                       clk,
    input  logic                       i_reset,
    input  mhq_pkg::mhq_line_addr_t    i_lookup_line,
    input  mhq_pkg::mhq_update_t       i_update,
    input  mhq_pkg::mhq_idx_t          i_tail,
    input  mhq_pkg::mhq_idx_t          i_head,
    input  logic                       i_free,
    output mhq_pkg::mhq_select_t       o_hit_select,
    output mhq_pkg::mhq_select_t       o_alloc_select,
    output mhq_pkg::mhq_select_t       o_bypass_select,
    output mhq_pkg::mhq_line_addr_t    o_bypass_addr,
    output mhq_pkg::mhq_entry_t        o_head_entry
);
    import mhq_pkg::*;

    mhq_select_t    valid;
    mhq_line_addr_t entry_addr [`MHQ_DEPTH];
    mhq_byte_mask_t entry_mask [`MHQ_DEPTH];
    mhq_line_t      entry_data [`MHQ_DEPTH];
    logic           entry_dirty [`MHQ_DEPTH];

    mhq_byte_mask_t next_mask [`MHQ_DEPTH];
    mhq_line_t      next_data [`MHQ_DEPTH];
    logic           next_dirty [`MHQ_DEPTH];
    mhq_select_t    update_match;
    mhq_select_t    free_select;

    // Entry contents after applying the pending update
    // A freshly allocated entry starts from an empty mask
    always_comb begin
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            next_mask[i]  = (valid[i] ? entry_mask[i] : '0) | i_update.byte_select;
            next_dirty[i] = (valid[i] && entry_dirty[i]) || i_update.we;
            next_data[i]  = entry_data[i];
            for (int b = 0; b < `MHQ_LINE_SIZE; b++) begin
                if (i_update.byte_select[b]) begin
                    next_data[i][b*8 +: 8] = i_update.wr_data[b*8 +: 8];
                end
            end
            update_match[i] = (entry_addr[i] == i_update.addr);
            o_hit_select[i] = valid[i] && (entry_addr[i] == i_lookup_line);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            if (i_update.select[i]) begin
                entry_addr[i]  <= i_update.addr;
                entry_mask[i]  <= next_mask[i];
                entry_data[i]  <= next_data[i];
                entry_dirty[i] <= next_dirty[i];
            end
        end
    end

    assign free_select = i_free ? (mhq_select_t'(1'b1) << i_head) : '0;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid <= '0;
        end else begin
            valid <= (valid | i_update.select) & ~free_select;
        end
    end

    assign o_alloc_select  = mhq_select_t'(1'b1) << i_tail;
    assign o_bypass_select = i_update.select;
    assign o_bypass_addr   = i_update.addr;

    // Head view forwards an update landing this cycle so the fill merge
    // never misses the last store into the line
    always_comb begin
        if (i_update.select[i_head]) begin
            o_head_entry.addr  = i_update.addr;
            o_head_entry.dirty = next_dirty[i_head];
            o_head_entry.mask  = next_mask[i_head];
            o_head_entry.data  = next_data[i_head];
        end else begin
            o_head_entry.addr  = entry_addr[i_head];
            o_head_entry.dirty = entry_dirty[i_head];
            o_head_entry.mask  = entry_mask[i_head];
            o_head_entry.data  = entry_data[i_head];
        end
    end

    // An occupied entry is only ever written again for its own line
    assert property (@(posedge clk) disable iff (i_reset)
        !(|(i_update.select & valid & ~update_match)));

endmodule

//--- mhq_control.sv
// ==========================================================
// Miss handling queue control
// Tracks head, tail and count, requests the head line from
// memory, merges the stored bytes and sends the fill
// ==========================================================

`timescale 1ns/1ns
`include "mhq_macros.svh"

module mhq_control (
    input  logic                       clk,
    input  logic                       i_reset,
    input  logic                       i_allocating,
    input  mhq_pkg::mhq_entry_t        i_head_entry,
    input  logic                       i_mem_req_ready,
    input  logic                       i_mem_rsp_valid,
    input  mhq_pkg::mhq_line_t         i_mem_rsp_line,
    output logic                       o_full,
    output mhq_pkg::mhq_idx_t          o_tail,
    output mhq_pkg::mhq_idx_t          o_head,
    output logic                       o_free,
    output logic                       o_completing,
    output mhq_pkg::mhq_line_addr_t    o_completing_addr,
    output logic                       o_filling,
    output mhq_pkg::mhq_line_addr_t    o_filling_addr,
    output logic                       o_mem_req_valid,
    output mhq_pkg::mhq_mem_req_t      o_mem_req,
    output logic                       o_fill_valid,
    output mhq_pkg::mhq_fill_t         o_fill
);
    import mhq_pkg::*;

    mhq_fill_state_e          state;
    mhq_fill_state_e          state_next;
    logic [`MHQ_IDX_WIDTH:0]  count;
    mhq_line_t                merged_line;
    mhq_fill_t                fill_q;

    always_comb begin
        state_next = state;
        unique case (state)
            ST_IDLE:    if (count != '0) state_next = ST_REQUEST;
            ST_REQUEST: if (i_mem_req_ready) state_next = ST_WAIT;
            ST_WAIT:    if (i_mem_rsp_valid) state_next = ST_FILL;
            ST_FILL:    state_next = ST_IDLE;
            default:    state_next = ST_IDLE;
        endcase
    end

    // The entry leaves the queue at the end of the fill cycle
    assign o_free = (state == ST_FILL);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= ST_IDLE;
            o_head <= '0;
            o_tail <= '0;
            count <= '0;
        end else begin
            state <= state_next;
            if (o_free) o_head <= o_head + 1'b1;
            if (i_allocating) o_tail <= o_tail + 1'b1;
            unique case ({i_allocating, o_free})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign o_full = (count == (`MHQ_IDX_WIDTH+1)'(`MHQ_DEPTH));

    assign o_mem_req_valid = (state == ST_REQUEST);
    assign o_mem_req.addr  = i_head_entry.addr;

    // Stored store bytes override the memory bytes under the mask
    always_comb begin
        for (int b = 0; b < `MHQ_LINE_SIZE; b++) begin
            if (i_head_entry.dirty && i_head_entry.mask[b]) begin
                merged_line[b*8 +: 8] = i_head_entry.data[b*8 +: 8];
            end else begin
                merged_line[b*8 +: 8] = i_mem_rsp_line[b*8 +: 8];
            end
        end
    end

    assign o_completing      = (state == ST_WAIT) && i_mem_rsp_valid;
    assign o_completing_addr = i_head_entry.addr;

    always_ff @(posedge clk) begin
        if (o_completing) begin
            fill_q.addr <= i_head_entry.addr;
            fill_q.line <= merged_line;
        end
    end

    assign o_fill_valid   = (state == ST_FILL);
    assign o_fill         = fill_q;
    assign o_filling      = o_fill_valid;
    assign o_filling_addr = fill_q.addr;

    // Memory request holds its line until memory takes it
    assert property (@(posedge clk) disable iff (i_reset)
        (o_mem_req_valid && !i_mem_req_ready) |=> (o_mem_req_valid && $stable(o_mem_req)));

    // The lookup never allocates into a full queue
    assert property (@(posedge clk) disable iff (i_reset) !(i_allocating && o_full));

endmodule

//--- mhq_top.sv
// ==========================================================
// Miss handling queue top level
// Connects lookup stage, entry array and control to the
// load/store unit and memory ports
// ==========================================================

`timescale 1ns/1ns
`include "mhq_macros.svh"

module mhq_top (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_lookup_valid,
    input  mhq_pkg::mhq_lookup_req_t    i_lookup,
    input  logic                        i_mem_req_ready,
    input  logic                        i_mem_rsp_valid,
    input  mhq_pkg::mhq_line_t          i_mem_rsp_line,
    output mhq_pkg::mhq_lookup_rsp_t    o_lookup_rsp,
    output logic                        o_lookup_rsp_valid,
    output logic                        o_mem_req_valid,
    output mhq_pkg::mhq_mem_req_t       o_mem_req,
    output logic                        o_fill_valid,
    output mhq_pkg::mhq_fill_t          o_fill
);
    import mhq_pkg::*;

    logic           full;
    logic           allocating;
    logic           free;
    logic           completing;
    logic           filling;
    mhq_line_addr_t completing_addr;
    mhq_line_addr_t filling_addr;
    mhq_line_addr_t bypass_addr;
    mhq_select_t    hit_select;
    mhq_select_t    alloc_select;
    mhq_select_t    bypass_select;
    mhq_idx_t       head;
    mhq_idx_t       tail;
    mhq_update_t    update;
    mhq_entry_t     head_entry;

    mhq_lookup lookup_i (
        .clk(clk),
        .i_reset(i_reset),
        .i_valid(i_lookup_valid),
        .i_req(i_lookup),
        .i_full(full),
        .i_hit_select(hit_select),
        .i_alloc_select(alloc_select),
        .i_bypass_select(bypass_select),
        .i_bypass_addr(bypass_addr),
        .i_completing(completing),
        .i_completing_addr(completing_addr),
        .i_filling(filling),
        .i_filling_addr(filling_addr),
        .o_rsp(o_lookup_rsp),
        .o_rsp_valid(o_lookup_rsp_valid),
        .o_allocating(allocating),
        .o_update(update)
    );

    mhq_entry_array entry_array_i (
        .clk(clk),
        .i_reset(i_reset),
        .i_lookup_line(i_lookup.addr[`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH]),
        .i_update(update),
        .i_tail(tail),
        .i_head(head),
        .i_free(free),
        .o_hit_select(hit_select),
        .o_alloc_select(alloc_select),
        .o_bypass_select(bypass_select),
        .o_bypass_addr(bypass_addr),
        .o_head_entry(head_entry)
    );

    mhq_control control_i (
        .clk(clk),
        .i_reset(i_reset),
        .i_allocating(allocating),
        .i_head_entry(head_entry),
        .i_mem_req_ready(i_mem_req_ready),
        .i_mem_rsp_valid(i_mem_rsp_valid),
        .i_mem_rsp_line(i_mem_rsp_line),
        .o_full(full),
        .o_tail(tail),
        .o_head(head),
        .o_free(free),
        .o_completing(completing),
        .o_completing_addr(completing_addr),
        .o_filling(filling),
        .o_filling_addr(filling_addr),
        .o_mem_req_valid(o_mem_req_valid),
        .o_mem_req(o_mem_req),
        .o_fill_valid(o_fill_valid),
        .o_fill(o_fill)
    );

endmodule

//--- tb_mhq.sv
// ==========================================================
// Miss handling queue testbench
// Replays lookups from the stimulus file, models memory,
// keeps a reference of every queued line and checks the
// lookup responses, memory requests and fills
// ==========================================================

`timescale 1ns/1ns
`include "mhq_macros.svh"

module tb_mhq;
    import mhq_pkg::*;

    localparam int TIMEOUT_CYCLES = 1000;

    logic                clk;
    logic                i_reset;
    logic                i_lookup_valid;
    mhq_lookup_req_t     i_lookup;
    logic                i_mem_req_ready;
    logic                i_mem_rsp_valid;
    mhq_line_t           i_mem_rsp_line;
    mhq_lookup_rsp_t     o_lookup_rsp;
    logic                o_lookup_rsp_valid;
    logic                o_mem_req_valid;
    mhq_mem_req_t        o_mem_req;
    logic                o_fill_valid;
    mhq_fill_t           o_fill;

    // Expected lookup responses in issue order and expected entries in queue order
    mhq_lookup_rsp_t     expect_q [$];
    mhq_entry_t          model_q [$];

    // State of the memory model that only the stimulus process touches
    logic                rsp_pending;
    int                  rsp_count;
    mhq_line_addr_t      rsp_addr;
    logic                accept_armed;
    int                  accept_delay;
    int                  cur_latency;
    logic                rsp_due;
    logic                fill_due;

    mhq_top dut_i (
        .clk(clk),
        .i_reset(i_reset),
        .i_lookup_valid(i_lookup_valid),
        .i_lookup(i_lookup),
        .i_mem_req_ready(i_mem_req_ready),
        .i_mem_rsp_valid(i_mem_rsp_valid),
        .i_mem_rsp_line(i_mem_rsp_line),
        .o_lookup_rsp(o_lookup_rsp),
        .o_lookup_rsp_valid(o_lookup_rsp_valid),
        .o_mem_req_valid(o_mem_req_valid),
        .o_mem_req(o_mem_req),
        .o_fill_valid(o_fill_valid),
        .o_fill(o_fill)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic check_lookup(mhq_lookup_rsp_t got, mhq_lookup_rsp_t exp);
        if (got !== exp) begin
            $display("FAIL o_lookup_rsp got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_fill(mhq_fill_t got, mhq_fill_t exp);
        if (got !== exp) begin
            $display("FAIL o_fill got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_mem_req(mhq_mem_req_t got, mhq_mem_req_t exp);
        if (got !== exp) begin
            $display("FAIL o_mem_req got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    // Every memory byte folds all four bytes of its own address
    function automatic mhq_line_t memory_line(mhq_line_addr_t line_addr);
        mhq_line_t                  line;
        logic [`MHQ_ADDR_WIDTH-1:0] byte_addr;
        for (int b = 0; b < `MHQ_LINE_SIZE; b++) begin
            byte_addr = {line_addr, 4'(b)};
            line[b*8 +: 8] = byte_addr[7:0] ^ byte_addr[15:8] ^ byte_addr[23:16]
                           ^ byte_addr[31:24];
        end
        return line;
    endfunction

    // Stored bytes win under the mask, memory fills the rest
    function automatic mhq_fill_t expected_fill(mhq_entry_t entry);
        mhq_fill_t fill;
        mhq_line_t mem;
        mem       = memory_line(entry.addr);
        fill.addr = entry.addr;
        for (int b = 0; b < `MHQ_LINE_SIZE; b++) begin
            fill.line[b*8 +: 8] = entry.mask[b] ? entry.data[b*8 +: 8] : mem[b*8 +: 8];
        end
        return fill;
    endfunction

    // Merge one accepted lookup into the reference entry for its line
    task automatic update_reference(mhq_lookup_req_t req);
        mhq_line_addr_t line_addr;
        mhq_entry_t     entry;
        int             idx;
        int             size;
        int             pos;
        line_addr = req.addr[`MHQ_ADDR_WIDTH-1:`MHQ_OFFSET_WIDTH];
        idx = -1;
        foreach (model_q[i]) begin
            if (model_q[i].addr == line_addr) idx = i;
        end
        if (idx < 0) begin
            entry      = '0;
            entry.addr = line_addr;
            model_q.push_back(entry);
            idx = model_q.size() - 1;
        end
        entry = model_q[idx];
        case (req.op)
            OP_SB:   size = 1;
            OP_SH:   size = 2;
            OP_SW:   size = 4;
            default: size = 0;
        endcase
        for (int k = 0; k < size; k++) begin
            pos = int'(req.addr[`MHQ_OFFSET_WIDTH-1:0]) + k;
            // Bytes past the line end are dropped
            if (pos < `MHQ_LINE_SIZE) begin
                entry.mask[pos]          = 1'b1;
                entry.data[pos*8 +: 8]   = req.data[k*8 +: 8];
            end
        end
        entry.dirty = entry.dirty | req.we;
        model_q[idx] = entry;
    endtask

    // Memory accepts after a random delay and answers after the latency
    task automatic step_memory();
        mhq_mem_req_t exp_req;
        i_mem_rsp_valid <= 1'b0;
        i_mem_req_ready <= 1'b0;
        if (rsp_pending) begin
            if (rsp_count == 0) begin
                i_mem_rsp_valid <= 1'b1;
                i_mem_rsp_line  <= memory_line(rsp_addr);
                rsp_pending = 1'b0;
            end else begin
                rsp_count--;
            end
        end else if (o_mem_req_valid) begin
            if (i_mem_req_ready) begin
                if (model_q.size() == 0) report_failure("memory request with an empty queue");
                exp_req.addr = model_q[0].addr;
                check_mem_req(o_mem_req, exp_req);
                rsp_addr     = o_mem_req.addr;
                rsp_pending  = 1'b1;
                rsp_count    = cur_latency;
                accept_armed = 1'b0;
            end else begin
                if (!accept_armed) begin
                    accept_armed = 1'b1;
                    accept_delay = $urandom % 4;
                end
                if (accept_delay == 0) begin
                    i_mem_req_ready <= 1'b1;
                end else begin
                    accept_delay--;
                end
            end
        end
    endtask

    // Advances one clock edge and reads the outputs as they stood before the edge
    task automatic next_edge();
        mhq_lookup_rsp_t exp_rsp;
        @(posedge clk);
        rsp_due  = rsp_pending && (rsp_count == 0);
        fill_due = i_mem_rsp_valid;
        i_lookup_valid <= 1'b0;
        if (o_lookup_rsp_valid) begin
            if (expect_q.size() == 0) report_failure("lookup response with no lookup issued");
            exp_rsp = expect_q.pop_front();
            check_lookup(o_lookup_rsp, exp_rsp);
        end
        if (o_fill_valid) begin
            if (model_q.size() == 0) report_failure("fill output with no queued entry");
            check_fill(o_fill, expected_fill(model_q.pop_front()));
        end
        step_memory();
    endtask

    function automatic logic drained();
        return (model_q.size() == 0) && (expect_q.size() == 0) && !rsp_pending;
    endfunction

    // Sync 0 next edge, 1 after the last response, 2 queue empty,
    // 3 memory response cycle, 4 fill cycle
    task automatic wait_for_sync(int sync);
        int   cycles;
        logic go;
        cycles = 0;
        go     = 1'b0;
        while (!go) begin
            next_edge();
            case (sync)
                0:       go = 1'b1;
                1:       go = (expect_q.size() == 0);
                2:       go = drained();
                3:       go = rsp_due;
                4:       go = fill_due;
                default: report_failure("unknown sync code in stimulus file");
            endcase
            cycles++;
            if (!go && cycles > TIMEOUT_CYCLES) begin
                report_failure("timeout waiting for the DUT");
            end
        end
    endtask

    initial begin
        int              fd;
        int              n;
        string           line;
        int              sync;
        int              op;
        int              hit;
        logic [31:0]     addr;
        logic [31:0]     data;
        int              lat;
        int              tag;
        int              retry;
        int              replay;
        mhq_lookup_req_t req;
        mhq_lookup_rsp_t exp;
        clk             = 1'b0;
        i_reset         = 1'b1;
        i_lookup_valid  = 1'b0;
        i_lookup        = '0;
        i_mem_req_ready = 1'b0;
        i_mem_rsp_valid = 1'b0;
        i_mem_rsp_line  = '0;
        rsp_pending     = 1'b0;
        rsp_count       = 0;
        rsp_addr        = '0;
        accept_armed    = 1'b0;
        accept_delay    = 0;
        cur_latency     = 0;
        void'($urandom(32'hfef2_6335));
        fd = $fopen("mhq_stim.txt", "r");
        if (fd == 0) report_failure("cannot open the stimulus file");
        repeat (16) @(posedge clk);
        i_reset <= 1'b0;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 4 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        sync, op, hit, addr, data, lat, tag, retry, replay);
            if (n != 9) report_failure("malformed line in the stimulus file");
            wait_for_sync(sync);
            req.we     = (op >= 1) && (op <= 3);
            req.dc_hit = hit[0];
            req.addr   = addr;
            req.op     = mhq_op_e'(op[2:0]);
            req.data   = data;
            exp.tag    = mhq_idx_t'(tag);
            exp.retry  = retry[0];
            exp.replay = replay[0];
            i_lookup_valid <= 1'b1;
            i_lookup       <= req;
            expect_q.push_back(exp);
            cur_latency = lat;
            if (!exp.retry && !exp.replay && !req.dc_hit && req.op != OP_FILL) begin
                update_reference(req);
            end
        end
        $fclose(fd);
        // Let every queued line finish its fill
        wait_for_sync(2);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- mhq_stim.txt
# sync op dc_hit addr data latency tag retry replay (all hex)
# sync 0 next edge 1 after response 2 drained 3 mem response cycle 4 fill cycle; op 0 ld 1 sb 2 sh 3 sw 4 fill
1 3 0 00001004 a1b2c3d4 05 0 0 0
2 1 0 00002000 00000011 28 1 0 0
1 2 0 00002006 00003322 28 1 0 0
1 3 0 0000200e 77665544 28 1 0 0
1 1 0 00002009 00000099 28 1 0 0
2 3 0 00003000 01020304 28 2 0 0
0 1 0 00003005 00000055 28 2 0 0
1 1 0 00003006 00000066 28 2 0 0
2 0 0 00004000 00000000 40 3 0 0
1 3 0 00005004 deadbeef 40 0 0 0
1 2 0 0000600a 0000cafe 40 1 0 0
1 1 0 0000700f 0000005a 40 2 0 0
1 3 0 00008000 12345678 40 3 1 0
1 1 0 00005007 00000077 40 0 0 0
2 3 0 0000a000 0a0b0c0d 10 3 0 0
3 1 0 0000a002 000000ff 10 3 0 1
4 2 0 0000a004 0000eeee 10 3 0 1
1 1 0 0000a001 00000077 10 0 0 0
2 3 1 0000b000 11111111 08 1 0 0
1 4 0 0000b000 00000000 08 1 0 0
1 0 0 0000c008 00000000 08 1 0 0

//--- mhq.f
+incdir+.
mhq_pkg.sv
mhq_lookup.sv
mhq_entry_array.sv
mhq_control.sv
mhq_top.sv
tb_mhq.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the miss handling queue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mhq.f --top-module tb_mhq -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mhq
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
echo "Simulation finished"
exit 0
